// File: hw/pixel_defs.svh
// pixel readout defines: address map, memory and FIFO depths, data identifiers
`ifndef PIXEL_DEFS_SVH
`define PIXEL_DEFS_SVH

// sequence generator registers and its playback memory
`define PIXEL_SEQ_BASE      16'h1000
`define PIXEL_SEQ_MEM_BASE  16'h1100

// capture status of the pixel shift register
`define PIXEL_RX_BASE       16'h0100

// fifo data bytes 0 to 3, word count at 4
`define PIXEL_FIFO_BASE     16'h0020

`define PIXEL_SEQ_DEPTH     256
`define PIXEL_FIFO_DEPTH    64
`define PIXEL_FIFO_NEAR     48

// identifiers in the top nibble of each readout word
`define PIXEL_ID_SR         4'b0010
`define PIXEL_ID_HIT        4'b0100

`endif

// File: hw/pixel_pkg.sv
// pixel_pkg: bus, readout word, timestamp and sequencer state types
`default_nettype none

package pixel_pkg;

    // host bus
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // identifier in [31:28], payload below
    typedef logic [31:0] word_t;

    // whole-cycle hit time
    typedef logic [27:0] stamp_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PLAY,
        SEQ_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: hw/seq_gen.sv
// seq_gen: sequence memory loaded over the bus and played out one byte per cycle
`default_nettype none
`timescale 1ns/10ps
`include "pixel_defs.svh"

module seq_gen (
    input  wire                  bus_clk,
    input  wire                  reset,
    input  wire pixel_pkg::bus_addr_t bus_addr,
    input  wire pixel_pkg::bus_data_t bus_wr_data,
    input  wire                  bus_wr,
    input  wire                  bus_rd,
    output pixel_pkg::bus_data_t bus_rd_data,
    output logic [7:0]           seq_out
);

    localparam int AW = $clog2(`PIXEL_SEQ_DEPTH);
    localparam pixel_pkg::bus_addr_t REG_BASE = `PIXEL_SEQ_BASE;
    localparam pixel_pkg::bus_addr_t MEM_BASE = `PIXEL_SEQ_MEM_BASE;
    localparam pixel_pkg::bus_addr_t MEM_SIZE = `PIXEL_SEQ_DEPTH;

    logic [7:0] mem [`PIXEL_SEQ_DEPTH];
    pixel_pkg::seq_state_t state;
    pixel_pkg::bus_addr_t mem_off;
    pixel_pkg::bus_data_t seq_len;
    logic [AW-1:0] play_addr;
    logic reg_sel;
    logic mem_sel;
    logic start;

    assign mem_off = bus_addr - MEM_BASE;
    assign mem_sel = mem_off < MEM_SIZE;
    assign reg_sel = bus_addr[15:4] == REG_BASE[15:4];
    assign start   = bus_wr && reg_sel && bus_addr[3:0] == 4'd0;

    always_ff @(posedge bus_clk) begin
        if (bus_wr && mem_sel) begin
            mem[mem_off[AW-1:0]] <= bus_wr_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            seq_len <= '0;
        end else if (bus_wr && reg_sel && bus_addr[3:0] == 4'd1) begin
            seq_len <= bus_wr_data;
        end
    end

    // start lands in play, first byte registered on the following edge
    always_ff @(posedge bus_clk) begin
        if (reset) begin
            state     <= pixel_pkg::SEQ_IDLE;
            play_addr <= '0;
            seq_out   <= '0;
        end else begin
            seq_out <= '0;
            if (start) begin
                play_addr <= '0;
                state     <= (seq_len == '0) ? pixel_pkg::SEQ_DONE : pixel_pkg::SEQ_PLAY;
            end else if (state == pixel_pkg::SEQ_PLAY) begin
                seq_out   <= mem[play_addr];
                play_addr <= play_addr + 1'b1;
                if (play_addr == AW'(seq_len - 8'd1)) begin
                    state <= pixel_pkg::SEQ_DONE;
                end
            end
        end
    end

    // reg 0 busy, reg 1 length, reg 2 done
    always_ff @(posedge bus_clk) begin
        if (reset) begin
            bus_rd_data <= '0;
        end else if (bus_rd && mem_sel) begin
            bus_rd_data <= mem[mem_off[AW-1:0]];
        end else if (bus_rd && reg_sel) begin
            case (bus_addr[3:0])
                4'd0:    bus_rd_data <= {7'd0, state == pixel_pkg::SEQ_PLAY};
                4'd1:    bus_rd_data <= seq_len;
                4'd2:    bus_rd_data <= {7'd0, state == pixel_pkg::SEQ_DONE};
                default: bus_rd_data <= '0;
            endcase
        end else begin
            bus_rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/sr_rx.sv
// sr_rx: pixel shift-register capture, packs serial bits into 16-bit data words
`default_nettype none
`timescale 1ns/10ps
`include "pixel_defs.svh"

module sr_rx (
    input  wire                  bus_clk,
    input  wire                  reset,
    input  wire                  sdi,
    input  wire                  sen,
    input  wire pixel_pkg::bus_addr_t bus_addr,
    input  wire                  bus_rd,
    output pixel_pkg::bus_data_t bus_rd_data,
    output logic                 empty,
    input  wire                  read,
    output pixel_pkg::word_t     data
);

    localparam pixel_pkg::bus_addr_t RX_BASE = `PIXEL_RX_BASE;

    logic [15:0] shift_q;
    logic [15:0] close_bits;
    logic [3:0]  bit_cnt;
    logic [3:0]  left_q;
    logic [11:0] word_cnt;
    logic sen_q;
    logic overflow;
    logic close_full;
    logic close_end;
    logic load;

    assign close_full = sen && bit_cnt == 4'd15;
    assign close_end  = !sen && sen_q && bit_cnt != 4'd0;
    // partial word shifted up so the first bit stays the msb
    assign close_bits = close_full ? {shift_q[14:0], sdi}
                                   : shift_q << (5'd16 - {1'b0, bit_cnt});
    // a closing word needs a free slot, otherwise it is dropped
    assign load = (close_full || close_end) && (empty || read);

    always_ff @(posedge bus_clk) begin
        if (sen) begin
            shift_q <= {shift_q[14:0], sdi};
        end
        if (load) begin
            data <= {`PIXEL_ID_SR, word_cnt, close_bits};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            sen_q    <= 1'b0;
            bit_cnt  <= '0;
            left_q   <= '0;
            word_cnt <= '0;
            overflow <= 1'b0;
            empty    <= 1'b1;
        end else begin
            sen_q <= sen;
            if (sen) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (sen_q) begin
                bit_cnt <= '0;
                left_q  <= bit_cnt;
            end
            if (read) begin
                empty <= 1'b1;
            end
            if (load) begin
                empty    <= 1'b0;
                word_cnt <= word_cnt + 1'b1;
            end else if (close_full || close_end) begin
                overflow <= 1'b1;
            end
        end
    end

    // status: sticky overflow in bit 7, leftover bits below
    always_ff @(posedge bus_clk) begin
        if (reset) begin
            bus_rd_data <= '0;
        end else if (bus_rd && bus_addr == RX_BASE) begin
            bus_rd_data <= {overflow, 3'd0, left_q};
        end else begin
            bus_rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/hit_stamp.sv
// hit stamp source tagging rising hit_or edges with a free-running timestamp
`default_nettype none
`timescale 1ns/10ps
`include "pixel_defs.svh"

module hit_stamp (
    input  wire              bus_clk,
    input  wire              reset,
    input  wire              hit_or,
    output logic             empty,
    input  wire              read,
    output pixel_pkg::word_t data
);

    pixel_pkg::stamp_t stamp;
    logic [2:0] hit_sync;
    logic rise;
    logic load;

    // two sync flops and a third one for the edge
    assign rise = hit_sync[1] && !hit_sync[2];
    // a hit while the last word is still pending is dropped
    assign load = rise && (empty || read);

    always_ff @(posedge bus_clk) begin
        if (load) begin
            data <= {`PIXEL_ID_HIT, stamp};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            stamp    <= '0;
            hit_sync <= '0;
            empty    <= 1'b1;
        end else begin
            stamp    <= stamp + 1'b1;
            hit_sync <= {hit_sync[1:0], hit_or};
            if (read) begin
                empty <= 1'b1;
            end
            if (load) begin
                empty <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rr_arbiter.sv
// rr_arbiter: round-robin merge of two word sources into one fifo write stream
`default_nettype none
`timescale 1ns/10ps

module rr_arbiter (
    input  wire                    bus_clk,
    input  wire                    reset,
    input  wire [1:0]              empty,
    output logic [1:0]             read,
    input  wire pixel_pkg::word_t [1:0] data_in,
    input  wire                    ready,
    output logic                   write,
    output pixel_pkg::word_t       data_out
);

    logic [1:0] req;
    logic last;

    // nothing granted while the fifo is full
    assign req = ~empty & {2{ready}};

    always_comb begin
        if (req == 2'b11) begin
            // both waiting, take the one not served last
            read = last ? 2'b01 : 2'b10;
        end else begin
            read = req;
        end
    end

    assign write    = |read;
    assign data_out = read[1] ? data_in[1] : data_in[0];

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            last <= 1'b0;
        end else if (write) begin
            last <= read[1];
        end
    end

endmodule

`default_nettype wire

// File: hw/out_fifo.sv
// out_fifo: output word fifo read byte by byte over the host bus
`default_nettype none
`timescale 1ns/10ps
`include "pixel_defs.svh"

module out_fifo (
    input  wire                  bus_clk,
    input  wire                  reset,
    input  wire                  write,
    input  wire pixel_pkg::word_t data,
    output logic                 ready,
    output logic                 near_full,
    input  wire pixel_pkg::bus_addr_t bus_addr,
    input  wire                  bus_rd,
    output pixel_pkg::bus_data_t bus_rd_data
);

    localparam int AW = $clog2(`PIXEL_FIFO_DEPTH);
    localparam pixel_pkg::bus_addr_t BASE = `PIXEL_FIFO_BASE;
    localparam logic [AW:0] FULL = `PIXEL_FIFO_DEPTH;
    localparam logic [AW:0] NEAR = `PIXEL_FIFO_NEAR;

    pixel_pkg::word_t mem [`PIXEL_FIFO_DEPTH];
    pixel_pkg::word_t head;
    pixel_pkg::bus_addr_t off;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;
    logic sel;
    logic push;
    logic pop;

    assign off       = bus_addr - BASE;
    assign sel       = bus_rd && off < 16'd5;
    assign ready     = count != FULL;
    assign near_full = count >= NEAR;
    assign push      = write && ready;
    // byte 3 is the last byte of a word, reading it pops
    assign pop       = sel && off[2:0] == 3'd3 && count != '0;
    assign head      = (count != '0) ? mem[rd_ptr] : '0;

    always_ff @(posedge bus_clk) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

    always_ff @(posedge bus_clk) begin
        if (reset) begin
            bus_rd_data <= '0;
        end else if (sel) begin
            case (off[2:0])
                3'd0:    bus_rd_data <= head[7:0];
                3'd1:    bus_rd_data <= head[15:8];
                3'd2:    bus_rd_data <= head[23:16];
                3'd3:    bus_rd_data <= head[31:24];
                default: bus_rd_data <= pixel_pkg::bus_data_t'(count);
            endcase
        end else begin
            bus_rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_top.sv
// pixel_top: readout of the pixel test board, sequencer, capture, hits and output fifo
`default_nettype none
`timescale 1ns/10ps

module pixel_top (
    input  wire                  bus_clk,
    input  wire                  reset,
    input  wire pixel_pkg::bus_addr_t bus_addr,
    input  wire pixel_pkg::bus_data_t bus_wr_data,
    output pixel_pkg::bus_data_t bus_rd_data,
    input  wire                  bus_wr,
    input  wire                  bus_rd,
    output wire                  sr_in,
    output wire                  global_sr_en,
    output wire                  global_sr_clk,
    output wire                  global_ctr_ld,
    output wire                  global_dac_ld,
    output wire                  pixel_sr_en,
    output wire                  pixel_sr_clk,
    input  wire                  pixel_sr_out,
    input  wire                  hit_or,
    output wire                  inject,
    output wire                  near_full,
    output wire [7:0]            debug_d
);

    wire [7:0] seq_out;
    wire pixel_pkg::bus_data_t seq_rd_data;
    wire pixel_pkg::bus_data_t rx_rd_data;
    wire pixel_pkg::bus_data_t fifo_rd_data;

    wire rx_empty;
    wire rx_read;
    wire pixel_pkg::word_t rx_data;
    wire hit_empty;
    wire hit_read;
    wire pixel_pkg::word_t hit_data;

    wire arb_write;
    wire pixel_pkg::word_t arb_data;
    wire fifo_ready;

    seq_gen i_seq_gen (
        .bus_clk     (bus_clk),
        .reset       (reset),
        .bus_addr    (bus_addr),
        .bus_wr_data (bus_wr_data),
        .bus_wr      (bus_wr),
        .bus_rd      (bus_rd),
        .bus_rd_data (seq_rd_data),
        .seq_out     (seq_out)
    );

    // chip controls straight from the sequence byte
    assign sr_in         = seq_out[0];
    assign global_sr_en  = seq_out[1];
    assign global_ctr_ld = seq_out[2];
    assign global_dac_ld = seq_out[3];
    assign pixel_sr_en   = seq_out[4];
    assign inject        = seq_out[5];

    // shift clocks follow their enables, no ddr output stage here
    assign global_sr_clk = global_sr_en;
    assign pixel_sr_clk  = pixel_sr_en;
    assign debug_d       = seq_out;

    sr_rx i_sr_rx (
        .bus_clk     (bus_clk),
        .reset       (reset),
        .sdi         (pixel_sr_out),
        .sen         (pixel_sr_en),
        .bus_addr    (bus_addr),
        .bus_rd      (bus_rd),
        .bus_rd_data (rx_rd_data),
        .empty       (rx_empty),
        .read        (rx_read),
        .data        (rx_data)
    );

    hit_stamp i_hit_stamp (
        .bus_clk (bus_clk),
        .reset   (reset),
        .hit_or  (hit_or),
        .empty   (hit_empty),
        .read    (hit_read),
        .data    (hit_data)
    );

    // capture words on port 1, hit words on port 0
    rr_arbiter i_rr_arbiter (
        .bus_clk  (bus_clk),
        .reset    (reset),
        .empty    ({rx_empty, hit_empty}),
        .read     ({rx_read, hit_read}),
        .data_in  ({rx_data, hit_data}),
        .ready    (fifo_ready),
        .write    (arb_write),
        .data_out (arb_data)
    );

    out_fifo i_out_fifo (
        .bus_clk     (bus_clk),
        .reset       (reset),
        .write       (arb_write),
        .data        (arb_data),
        .ready       (fifo_ready),
        .near_full   (near_full),
        .bus_addr    (bus_addr),
        .bus_rd      (bus_rd),
        .bus_rd_data (fifo_rd_data)
    );

    // unaddressed slaves return zero
    assign bus_rd_data = seq_rd_data | rx_rd_data | fifo_rd_data;

endmodule

`default_nettype wire

// File: sim/tb_pixel.sv
// tb_pixel: table-driven testbench of the pixel readout with a loopback chip model
`default_nettype none
`timescale 1ns/10ps
`include "pixel_defs.svh"

module tb_pixel;

    localparam pixel_pkg::bus_addr_t SEQ_REG  = `PIXEL_SEQ_BASE;
    localparam pixel_pkg::bus_addr_t SEQ_MEM  = `PIXEL_SEQ_MEM_BASE;
    localparam pixel_pkg::bus_addr_t RX_STAT  = `PIXEL_RX_BASE;
    localparam pixel_pkg::bus_addr_t FIFO_DAT = `PIXEL_FIFO_BASE;
    localparam pixel_pkg::bus_addr_t FIFO_CNT = `PIXEL_FIFO_BASE + 16'd4;

    typedef enum logic [3:0] {
        OP_WRITE, OP_READ, OP_CHECKMEM, OP_FILL, OP_START,
        OP_HIT, OP_SETTLE, OP_POP, OP_NEAR, OP_DRAIN
    } op_t;

    typedef struct packed {
        op_t                  op;
        pixel_pkg::bus_addr_t addr;
        pixel_pkg::bus_data_t data;
        pixel_pkg::bus_data_t want;
    } row_t;

    localparam int N_ROWS = 35;
    // each row costs at most two cycles per sequence byte plus some overhead
    localparam int LIMIT = N_ROWS * 2 * (`PIXEL_SEQ_DEPTH + 16);

    localparam row_t ROWS [N_ROWS] = '{
        '{OP_READ,     FIFO_CNT,             8'h00, 8'h00},
        '{OP_READ,     SEQ_REG + 16'd2,      8'h00, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd0,      8'h02, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd1,      8'h03, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd2,      8'h04, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd3,      8'h11, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd4,      8'h10, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd5,      8'h11, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd6,      8'h11, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd7,      8'h08, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd8,      8'h20, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd9,      8'h31, 8'h00},
        '{OP_WRITE,    SEQ_MEM + 16'd10,     8'h00, 8'h00},
        '{OP_CHECKMEM, SEQ_MEM,              8'd11, 8'h00},
        '{OP_WRITE,    SEQ_REG + 16'd1,      8'd11, 8'h00},
        '{OP_READ,     SEQ_REG + 16'd1,      8'h00, 8'd11},
        '{OP_START,    SEQ_REG,              8'h00, 8'h00},
        '{OP_READ,     RX_STAT,              8'h00, 8'h01},
        '{OP_HIT,      16'h0000,             8'd3,  8'h00},
        '{OP_SETTLE,   FIFO_CNT,             8'h00, 8'h00},
        '{OP_READ,     FIFO_CNT,             8'h00, 8'd5},
        '{OP_DRAIN,    FIFO_CNT,             8'h00, 8'h00},
        '{OP_FILL,     SEQ_MEM,              8'd255, 8'h00},
        '{OP_CHECKMEM, SEQ_MEM,              8'd255, 8'h00},
        '{OP_WRITE,    SEQ_REG + 16'd1,      8'd255, 8'h00},
        '{OP_HIT,      16'h0000,             8'd6,  8'h00},
        '{OP_START,    SEQ_REG,              8'h00, 8'h00},
        '{OP_START,    SEQ_REG,              8'h00, 8'h00},
        '{OP_START,    SEQ_REG,              8'h00, 8'h00},
        '{OP_SETTLE,   FIFO_CNT,             8'h00, 8'h00},
        '{OP_NEAR,     16'h0000,             8'h00, 8'h01},
        '{OP_POP,      FIFO_DAT,             8'd10, 8'h00},
        '{OP_NEAR,     16'h0000,             8'h00, 8'h00},
        '{OP_READ,     RX_STAT,              8'h00, 8'h0f},
        '{OP_DRAIN,    FIFO_CNT,             8'h00, 8'h00}
    };

    logic bus_clk;
    logic reset;
    pixel_pkg::bus_addr_t bus_addr;
    pixel_pkg::bus_data_t bus_wr_data;
    pixel_pkg::bus_data_t bus_rd_data;
    logic bus_wr;
    logic bus_rd;
    logic sr_in;
    logic global_sr_en;
    logic global_sr_clk;
    logic global_ctr_ld;
    logic global_dac_ld;
    logic pixel_sr_en;
    logic pixel_sr_clk;
    logic pixel_sr_out;
    logic hit_or;
    logic inject;
    logic near_full;
    logic [7:0] debug_d;
    wire [7:0] ctrl_pins;

    // reference model state
    pixel_pkg::bus_data_t image [`PIXEL_SEQ_DEPTH];
    pixel_pkg::bus_data_t len_model;
    pixel_pkg::word_t exp_sr [$];
    int hit_cycles [$];
    logic [11:0] sr_count;
    logic have_ref;
    pixel_pkg::stamp_t ref_stamp;
    int ref_cycle;
    int hits_left;
    int cycle_count;
    int errors;
    logic [31:0] lfsr;

    pixel_top dut (
        .bus_clk       (bus_clk),
        .reset         (reset),
        .bus_addr      (bus_addr),
        .bus_wr_data   (bus_wr_data),
        .bus_rd_data   (bus_rd_data),
        .bus_wr        (bus_wr),
        .bus_rd        (bus_rd),
        .sr_in         (sr_in),
        .global_sr_en  (global_sr_en),
        .global_sr_clk (global_sr_clk),
        .global_ctr_ld (global_ctr_ld),
        .global_dac_ld (global_dac_ld),
        .pixel_sr_en   (pixel_sr_en),
        .pixel_sr_clk  (pixel_sr_clk),
        .pixel_sr_out  (pixel_sr_out),
        .hit_or        (hit_or),
        .inject        (inject),
        .near_full     (near_full),
        .debug_d       (debug_d)
    );

    // chip model, the pixel register hands sr_in straight back
    assign pixel_sr_out = sr_in;
    assign ctrl_pins = {pixel_sr_clk, global_sr_clk, inject, pixel_sr_en,
                        global_dac_ld, global_ctr_ld, global_sr_en, sr_in};

    initial bus_clk = 1'b0;
    always #2 bus_clk = ~bus_clk;

    always @(posedge bus_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] r;
        int k;
        r = '0;
        for (k = 0; k < n; k++) begin
            r = {r[6:0], next_bit()};
        end
        return r;
    endfunction

    // pixel enable always set so a full play is one long window
    function automatic pixel_pkg::bus_data_t fill_byte(input pixel_pkg::bus_addr_t a);
        logic [15:0] x;
        x = a ^ (a >> 5) ^ (a >> 11);
        return (x[7:0] & 8'hef) | 8'h10;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_pins(input pixel_pkg::bus_data_t b);
        check_value("control pins", 32'(ctrl_pins), 32'({b[4], b[1], b[5:0]}));
        check_value("debug byte", 32'(debug_d), 32'(b));
    endtask

    task automatic bus_write(input pixel_pkg::bus_addr_t a, input pixel_pkg::bus_data_t d);
        pixel_pkg::bus_addr_t off;
        @(posedge bus_clk);
        bus_addr    <= a;
        bus_wr_data <= d;
        bus_wr      <= 1'b1;
        @(posedge bus_clk);
        bus_wr <= 1'b0;
        off = a - SEQ_MEM;
        if (off < 16'd256) begin
            image[off[7:0]] = d;
        end
        if (a == SEQ_REG + 16'd1) begin
            len_model = d;
        end
    endtask

    // data comes back one cycle after the strobe
    task automatic bus_read(input pixel_pkg::bus_addr_t a, output pixel_pkg::bus_data_t d);
        @(posedge bus_clk);
        bus_addr <= a;
        bus_rd   <= 1'b1;
        @(posedge bus_clk);
        bus_rd <= 1'b0;
        @(negedge bus_clk);
        d = bus_rd_data;
    endtask

    task automatic push_sr(input logic [15:0] bits);
        exp_sr.push_back({`PIXEL_ID_SR, sr_count, bits});
        sr_count = sr_count + 12'd1;
    endtask

    // words from the enable windows, msb first, last one zero padded
    task automatic expect_sr_words(input int n);
        logic [15:0] acc;
        int bits;
        int i;
        acc  = '0;
        bits = 0;
        for (i = 0; i <= n; i++) begin
            if (i < n && image[i[7:0]][4]) begin
                acc = {acc[14:0], image[i[7:0]][0]};
                bits++;
                if (bits == 16) begin
                    push_sr(acc);
                    bits = 0;
                end
            end else if (bits != 0) begin
                push_sr(acc << (16 - bits));
                bits = 0;
            end
        end
    endtask

    task automatic play_sequence();
        pixel_pkg::bus_data_t d;
        int i;
        @(posedge bus_clk);
        bus_addr    <= SEQ_REG;
        bus_wr_data <= 8'h00;
        bus_wr      <= 1'b1;
        @(posedge bus_clk);
        bus_wr <= 1'b0;
        for (i = 0; i < int'(len_model); i++) begin
            @(posedge bus_clk);
            @(negedge bus_clk);
            check_pins(image[i[7:0]]);
        end
        @(posedge bus_clk);
        @(negedge bus_clk);
        check_pins(8'h00);
        expect_sr_words(int'(len_model));
        bus_read(SEQ_REG + 16'd2, d);
        check_value("done bit", 32'(d), 32'd1);
    endtask

    task automatic check_word(input pixel_pkg::word_t w);
        pixel_pkg::word_t want;
        pixel_pkg::stamp_t stamp_diff;
        pixel_pkg::stamp_t cycle_diff;
        int c;
        assert (w[31:28] == `PIXEL_ID_SR || w[31:28] == `PIXEL_ID_HIT) else begin
            errors++;
            $display("word %h at %0t has an unknown identifier", w, $time);
        end
        case (w[31:28])
            `PIXEL_ID_SR: begin
                assert (exp_sr.size() != 0) else begin
                    errors++;
                    $display("sr word %h at %0t was not expected", w, $time);
                end
                if (exp_sr.size() != 0) begin
                    want = exp_sr.pop_front();
                    check_value("sr word", w, want);
                end
            end
            `PIXEL_ID_HIT: begin
                assert (hit_cycles.size() != 0) else begin
                    errors++;
                    $display("hit word %h at %0t without a driven hit", w, $time);
                end
                if (hit_cycles.size() != 0) begin
                    c = hit_cycles.pop_front();
                    if (!have_ref) begin
                        ref_stamp = w[27:0];
                        ref_cycle = c;
                        have_ref  = 1'b1;
                    end else begin
                        stamp_diff = w[27:0] - ref_stamp;
                        cycle_diff = pixel_pkg::stamp_t'(c - ref_cycle);
                        check_value("hit stamp offset", 32'(stamp_diff), 32'(cycle_diff));
                    end
                end
            end
            default: begin
            end
        endcase
    endtask

    // byte 3 pops the head word
    task automatic pop_word();
        pixel_pkg::bus_data_t d;
        pixel_pkg::word_t w;
        int k;
        w = '0;
        for (k = 0; k < 4; k++) begin
            bus_read(FIFO_DAT + 16'(k), d);
            w = {d, w[31:8]};
        end
        check_word(w);
    endtask

    task automatic wait_settled();
        pixel_pkg::bus_data_t d;
        logic settled;
        settled = 1'b0;
        while (!settled) begin
            bus_read(FIFO_CNT, d);
            settled = hits_left == 0 && int'(d) == exp_sr.size() + hit_cycles.size();
        end
    endtask

    task automatic drain_fifo();
        pixel_pkg::bus_data_t d;
        int i;
        bus_read(FIFO_CNT, d);
        for (i = 0; i < int'(d); i++) begin
            pop_word();
        end
        assert (exp_sr.size() == 0 && hit_cycles.size() == 0) else begin
            errors++;
            $display("words never reached the fifo by %0t: %0d sr, %0d hit",
                     $time, exp_sr.size(), hit_cycles.size());
        end
        bus_read(FIFO_CNT, d);
        check_value("fifo count after drain", 32'(d), 32'd0);
    endtask

    // hit_or pulses, random gap of 4 to 19 cycles before each
    initial begin : hit_driver
        int gap;
        forever begin
            @(posedge bus_clk);
            if (hits_left > 0) begin
                gap = 4 + int'(random_bits(4));
                repeat (gap) @(posedge bus_clk);
                hit_or <= 1'b1;
                hit_cycles.push_back(cycle_count);
                repeat (2) @(posedge bus_clk);
                hit_or    <= 1'b0;
                hits_left = hits_left - 1;
            end
        end
    end

    initial begin : run_table
        row_t row;
        pixel_pkg::bus_data_t d;
        int r;
        int i;
        bus_addr    = '0;
        bus_wr_data = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        hit_or      = 1'b0;
        reset       = 1'b1;
        lfsr        = 32'h3463;
        sr_count    = '0;
        have_ref    = 1'b0;
        ref_stamp   = '0;
        ref_cycle   = 0;
        hits_left   = 0;
        cycle_count = 0;
        errors      = 0;
        len_model   = '0;
        repeat (16) @(posedge bus_clk);
        reset <= 1'b0;
        @(negedge bus_clk);
        check_pins(8'h00);
        check_value("near_full after reset", 32'(near_full), 32'd0);

        for (r = 0; r < N_ROWS; r++) begin
            row = ROWS[r];
            case (row.op)
                OP_WRITE: bus_write(row.addr, row.data);
                OP_READ: begin
                    bus_read(row.addr, d);
                    check_value($sformatf("read of %h", row.addr), 32'(d), 32'(row.want));
                end
                OP_CHECKMEM: begin
                    for (i = 0; i < int'(row.data); i++) begin
                        bus_read(row.addr + 16'(i), d);
                        check_value($sformatf("memory byte %0d", i), 32'(d),
                                    32'(image[i[7:0]]));
                    end
                end
                OP_FILL: begin
                    for (i = 0; i < int'(row.data); i++) begin
                        bus_write(row.addr + 16'(i), fill_byte(row.addr + 16'(i)));
                    end
                end
                OP_START: play_sequence();
                OP_HIT: hits_left = int'(row.data);
                OP_SETTLE: wait_settled();
                OP_POP: begin
                    for (i = 0; i < int'(row.data); i++) begin
                        pop_word();
                    end
                end
                OP_NEAR: check_value("near_full", 32'(near_full), 32'(row.want));
                OP_DRAIN: drain_fifo();
                default: begin
                end
            endcase
        end

        $display("%0d rows applied, %0d errors", N_ROWS, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/pixel_pkg.sv
hw/seq_gen.sv
hw/sr_rx.sv
hw/hit_stamp.sv
hw/rr_arbiter.sv
hw/out_fifo.sv
hw/pixel_top.sv
sim/tb_pixel.sv

// File: Makefile
SOURCES := build.f $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/tb_pixel: $(SOURCES)
	verilator --binary --timing --assert -f build.f --top-module tb_pixel \
		-Mdir obj_dir -o tb_pixel

run: obj_dir/tb_pixel
	./obj_dir/tb_pixel | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
